// ==== files.f ====
verilog/tracker_pkg.sv
verilog/rgb_to_ycrcb.sv
verilog/mask_stage.sv
verilog/bounding_box.sv
verilog/center_of_mass.sv
verilog/overlay_render.sv
verilog/color_tracker.sv
testbench/tb_color_tracker.sv

// ==== testbench/tb_color_tracker.sv ====
`timescale 1ns/100ps

module tb_color_tracker import tracker_pkg::*; ();

  localparam int frame_w = 32;        // active pixels per row
  localparam int frame_h = 16;        // active rows
  localparam int blank_w = 4;         // blanking beats after each row
  localparam int wait_limit = 2000;   // cycles allowed for an update pulse
  localparam int quiet_window = 100;  // longer than one full divide

  typedef enum {frame_shirt, frame_plain, frame_dark_box} frame_kind_e;

  logic        clk_pixel;
  logic        sys_rst;
  video_beat_t beat;
  channel_e    channel_sel;
  logic [3:0]  lower_nib, upper_nib;
  rgb_t        pixel_out;
  logic        pixel_active;
  location_t   location;
  logic        box_update, saber_update;

  // model of the location register
  box_t           loc_box, exp_box;   // held box and box of the frame just sent
  logic [h_w-1:0] loc_sx, exp_sx;
  logic [v_w-1:0] loc_sy, exp_sy;
  int             exp_n;              // saber pixels in the frame just sent
  logic           box_armed = 1'b0;   // frame pulse sent, box_update allowed
  logic           saber_armed = 1'b0;

  // expected pixel of the beat on the bus, then 5 beats of delay
  rgb_t       exp_pix;
  logic       exp_act = 1'b0;
  logic       exp_on = 1'b0;
  rgb_t       exp_pix_q [5];
  logic [4:0] exp_act_q = '0;
  logic [4:0] exp_on_q = '0;

  int pixel_errors = 0;
  int loc_errors = 0;
  int pulse_errors = 0;
  int timeout_errors = 0;

  color_tracker DUT (
    .clk_pixel    (clk_pixel),
    .sys_rst      (sys_rst),
    .beat         (beat),
    .channel_sel  (channel_sel),
    .lower_nib    (lower_nib),
    .upper_nib    (upper_nib),
    .pixel_out    (pixel_out),
    .pixel_active (pixel_active),
    .location     (location),
    .box_update   (box_update),
    .saber_update (saber_update)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #4 clk_pixel = ~clk_pixel;
  end

  always @(posedge clk_pixel) begin
    exp_pix_q[0] <= exp_pix;
    for (int i = 4; i > 0; i--) exp_pix_q[i] <= exp_pix_q[i-1];
    exp_act_q <= {exp_act_q[3:0], exp_act};
    exp_on_q  <= {exp_on_q[3:0], exp_on};
  end

  // 565 to 888, low bits zero
  function automatic rgb_t expand(input logic [15:0] p);
    return '{r: {p[15:11], 3'b000}, g: {p[10:5], 2'b00}, b: {p[4:0], 3'b000}};
  endfunction

  function automatic logic [7:0] sat8(input int v);
    if (v < 0) return 8'h00;
    if (v > 255) return 8'hFF;
    return 8'(v);
  endfunction

  // BT.601 studio range, weights over 256
  function automatic logic [7:0] chan_value(input channel_e sel, input rgb_t c);
    int r, g, b;
    r = c.r;
    g = c.g;
    b = c.b;
    case (sel)
      ch_green: return c.g;
      ch_red:   return c.r;
      ch_blue:  return c.b;
      ch_y:     return sat8(((66 * r + 129 * g + 25 * b) >>> 8) + 16);
      ch_cr:    return sat8(((112 * r - 94 * g - 18 * b) >>> 8) + 128);
      ch_cb:    return sat8(((112 * b - 38 * r - 74 * g) >>> 8) + 128);
      default:  return 8'h00;  // codes 3 and 7
    endcase
  endfunction

  // irregular saber blob so the mean needs a real floor
  function automatic logic in_blob(input int x, input int y);
    return x >= 18 && x <= 27 && y >= 9 && y <= 14 && ((x + 2 * y) % 3 == 0);
  endfunction

  function automatic logic [15:0] frame_pixel(input frame_kind_e kind, input int x,
                                              input int y);
    if (kind == frame_shirt && x >= 5 && x <= 12 && y >= 3 && y <= 9)
      return 16'hF000;  // red 0xF0, the top value an upper bound reaches
    if (kind == frame_dark_box && x >= 8 && x <= 20 && y >= 2 && y <= 6)
      return 16'h0000;  // black, y of 16
    if (kind != frame_plain && in_blob(x, y))
      return 16'h0200;  // green 0x40, inside the saber band
    if (kind == frame_dark_box)
      return {2'b11, 3'($urandom), 3'b000, 3'($urandom), 5'($urandom)};  // bright
    return {2'b00, 3'($urandom), 3'b000, 3'($urandom), 2'b00, 3'($urandom)};  // dark
  endfunction

  function automatic logic box_matches(input box_t got, input box_t exp);
    if (exp.empty) return got.empty;  // extremes of an empty box are don't care
    return got == exp;
  endfunction

  task automatic drive_beat(input logic [h_w-1:0] h, input logic [v_w-1:0] v,
                            input logic [15:0] p, input logic act, input logic nf);
    @(posedge clk_pixel);
    #1;
    beat.hcount    = h;
    beat.vcount    = v;
    beat.rgb565    = p;
    beat.active    = act;
    beat.new_frame = nf;
    exp_on  = 1'b1;
    exp_act = act;
    if (!act) exp_pix = '0;
    else if (h == loc_sx || v == loc_sy) exp_pix = {3{crosshair_level}};
    else if (!loc_box.empty && h >= loc_box.x_min && h <= loc_box.x_max &&
             v >= loc_box.y_min && v <= loc_box.y_max) exp_pix = {3{box_level}};
    else exp_pix = expand(p);
  endtask

  task automatic drive_blank();
    drive_beat(h_w'(frame_w + blank_w), v_w'(frame_h), 16'h0, 1'b0, 1'b0);
  endtask

  task automatic select_channel(input channel_e sel, input logic [3:0] lo,
                                input logic [3:0] hi);
    channel_sel = sel;
    lower_nib   = lo;
    upper_nib   = hi;
  endtask

  // one frame of active rows, expected box and centre built on the way
  task automatic run_frame(input frame_kind_e kind);
    logic [15:0]    p;
    rgb_t           c;
    logic [7:0]     ch;
    logic [h_w-1:0] hx;
    logic [v_w-1:0] vy;
    logic           seen;
    int             sum_x, sum_y;
    seen  = 1'b0;
    sum_x = 0;
    sum_y = 0;
    exp_n = 0;
    for (int y = 0; y < frame_h; y++) begin
      for (int x = 0; x < frame_w + blank_w; x++) begin
        hx = h_w'(x);
        vy = v_w'(y);
        if (x >= frame_w) begin
          drive_beat(hx, vy, 16'h0, 1'b0, 1'b0);  // row blanking
        end else begin
          p  = frame_pixel(kind, x, y);
          c  = expand(p);
          ch = chan_value(channel_sel, c);
          if (ch >= {lower_nib, 4'h0} && ch <= {upper_nib, 4'h0}) begin
            if (!seen || hx < exp_box.x_min) exp_box.x_min = hx;
            if (!seen || hx > exp_box.x_max) exp_box.x_max = hx;
            if (!seen || vy < exp_box.y_min) exp_box.y_min = vy;
            if (!seen || vy > exp_box.y_max) exp_box.y_max = vy;
            seen = 1'b1;
          end
          if (c.g >= saber_lo && c.g <= saber_hi) begin
            sum_x += x;
            sum_y += y;
            exp_n++;
          end
          drive_beat(hx, vy, p, 1'b1, 1'b0);
        end
      end
    end
    exp_box.empty = !seen;
    if (exp_n != 0) begin
      exp_sx = h_w'(sum_x / exp_n);  // floor of the mean
      exp_sy = v_w'(sum_y / exp_n);
    end
  endtask

  // frame pulse, then wait for the location register to take the results
  task automatic end_frame();
    int cycles;
    drive_beat('0, '0, 16'h0, 1'b0, 1'b1);
    box_armed   = 1'b1;
    saber_armed = (exp_n != 0);
    cycles = 0;
    while (!box_update && cycles < wait_limit) begin
      drive_blank();
      cycles++;
    end
    if (!box_update) begin
      timeout_errors++;
      $display("box_update did not arrive within %0d cycles", wait_limit);
    end else begin
      loc_box = exp_box;
    end
    drive_blank();  // pulse still sampled high on this edge
    box_armed = 1'b0;
    if (saber_armed) begin
      cycles = 0;
      while (!saber_update && cycles < wait_limit) begin
        drive_blank();
        cycles++;
      end
      if (!saber_update) begin
        timeout_errors++;
        $display("saber_update did not arrive within %0d cycles", wait_limit);
      end else begin
        loc_sx = exp_sx;
        loc_sy = exp_sy;
      end
      drive_blank();
      saber_armed = 1'b0;
    end else begin
      repeat (quiet_window) drive_blank();  // no pulse may show up here
    end
    repeat (4) drive_blank();
  endtask

  a_pixel_out: assert property (@(posedge clk_pixel) exp_on_q[4] |-> pixel_out == exp_pix_q[4])
    else begin
      pixel_errors++;
      $display("CHECK FAILED pixel_out exp %h got %h", exp_pix_q[4], $sampled(pixel_out));
    end

  a_pixel_active: assert property (@(posedge clk_pixel)
    exp_on_q[4] |-> pixel_active == exp_act_q[4])
    else begin
      pixel_errors++;
      $display("CHECK FAILED pixel_active exp %h got %h", exp_act_q[4], $sampled(pixel_active));
    end

  a_box: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box_update |-> box_matches(location.box, exp_box))
    else begin
      loc_errors++;
      $display("CHECK FAILED location.box exp %h got %h", exp_box, $sampled(location.box));
    end

  a_saber_x: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    saber_update |-> location.saber_x == exp_sx)
    else begin
      loc_errors++;
      $display("CHECK FAILED location.saber_x exp %h got %h", exp_sx,
               $sampled(location.saber_x));
    end

  a_saber_y: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    saber_update |-> location.saber_y == exp_sy)
    else begin
      loc_errors++;
      $display("CHECK FAILED location.saber_y exp %h got %h", exp_sy,
               $sampled(location.saber_y));
    end

  // reset state holds until the first update
  a_reset_empty: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !box_armed && loc_box.empty && loc_sx == '0 |-> location.box.empty)
    else begin
      loc_errors++;
      $display("CHECK FAILED location.box.empty exp 1 got %h", $sampled(location.box.empty));
    end

  a_reset_saber: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !saber_armed && loc_sx == '0 && loc_sy == '0 |->
      location.saber_x == '0 && location.saber_y == '0)
    else begin
      loc_errors++;
      $display("CHECK FAILED location.saber_x exp 0 got %h, location.saber_y exp 0 got %h",
               $sampled(location.saber_x), $sampled(location.saber_y));
    end

  a_box_quiet: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !box_armed |-> !box_update)
    else begin
      pulse_errors++;
      $display("box_update pulsed with no frame boundary pending");
    end

  a_saber_quiet: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    !saber_armed |-> !saber_update)
    else begin
      pulse_errors++;
      $display("saber_update pulsed for a frame without saber pixels");
    end

  initial begin
    sys_rst = 1'b1;
    beat    = '0;
    exp_pix = '0;
    select_channel(ch_red, 4'hF, 4'hF);  // window 0xF0 to 0xF0
    loc_box = '0;
    loc_box.empty = 1'b1;
    exp_box = loc_box;
    loc_sx  = '0;
    loc_sy  = '0;
    exp_sx  = '0;
    exp_sy  = '0;
    exp_n   = 0;
    void'($urandom(82));
    repeat (2) @(posedge clk_pixel);
    #1;
    sys_rst = 1'b0;
    repeat (20) drive_blank();  // nothing may move before the first boundary
    end_frame();                // empty box, no saber
    run_frame(frame_shirt);
    end_frame();
    run_frame(frame_plain);     // no red and no saber
    end_frame();
    select_channel(ch_y, 4'h1, 4'h1);
    run_frame(frame_dark_box);
    end_frame();
    select_channel(ch_zero_a, 4'h0, 4'h0);  // zero channel, whole frame
    run_frame(frame_shirt);
    end_frame();
    select_channel(ch_zero_b, 4'h0, 4'h0);
    run_frame(frame_plain);
    end_frame();
    run_frame(frame_plain);     // drawn against the full frame box
    repeat (10) drive_blank();
    $display("errors: pixel %0d, location %0d, pulse %0d, timeout %0d",
             pixel_errors, loc_errors, pulse_errors, timeout_errors);
    if (pixel_errors + loc_errors + pulse_errors + timeout_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/bounding_box.sv ====
`timescale 1ns/100ps

module bounding_box import tracker_pkg::*; (
  input  logic        clk_pixel,
  input  logic        sys_rst,
  input  video_beat_t beat_d,
  input  logic        shirt_mask,
  output box_t        box,        // extremes of the frame just ended
  output logic        box_valid   // one beat after the frame pulse
);

  logic [h_w-1:0] x_min_q, x_max_q;  // running extremes
  logic [v_w-1:0] y_min_q, y_max_q;
  logic           seen_q;            // at least one mask pixel this frame

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      seen_q    <= 1'b0;
      x_min_q   <= '1;
      y_min_q   <= '1;
      x_max_q   <= '0;
      y_max_q   <= '0;
      box       <= box_none;
      box_valid <= 1'b0;
    end else begin
      box_valid <= beat_d.new_frame;
      if (beat_d.new_frame) begin
        // publish, then restart with the boundary beat itself
        box.x_min <= x_min_q;
        box.y_min <= y_min_q;
        box.x_max <= x_max_q;
        box.y_max <= y_max_q;
        box.empty <= ~seen_q;
        seen_q    <= shirt_mask;
        x_min_q   <= shirt_mask ? beat_d.hcount : '1;
        y_min_q   <= shirt_mask ? beat_d.vcount : '1;
        x_max_q   <= shirt_mask ? beat_d.hcount : '0;
        y_max_q   <= shirt_mask ? beat_d.vcount : '0;
      end else if (shirt_mask) begin
        seen_q <= 1'b1;
        if (beat_d.hcount < x_min_q) begin
          x_min_q <= beat_d.hcount;
        end
        if (beat_d.hcount > x_max_q) begin
          x_max_q <= beat_d.hcount;
        end
        if (beat_d.vcount < y_min_q) begin
          y_min_q <= beat_d.vcount;
        end
        if (beat_d.vcount > y_max_q) begin
          y_max_q <= beat_d.vcount;
        end
      end
    end
  end

  // a published box that is not empty must be well ordered
  a_box_order: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box_valid && !box.empty |-> (box.x_min <= box.x_max) && (box.y_min <= box.y_max));

endmodule

// ==== verilog/center_of_mass.sv ====
`timescale 1ns/100ps

module center_of_mass import tracker_pkg::*; (
  input  logic           clk_pixel,
  input  logic           sys_rst,
  input  video_beat_t    beat_d,
  input  logic           saber_mask,
  output logic [h_w-1:0] saber_x,      // floor of mean hcount
  output logic [v_w-1:0] saber_y,      // floor of mean vcount
  output logic           saber_valid
);

  logic [sum_w-1:0]     x_acc, y_acc, n_acc;  // sums of the running frame
  logic [sum_w-1:0]     den_q;                // pixel count of the captured frame
  logic [sum_w-1:0]     num_y_q;              // y sum, waits for divide_y
  logic [sum_w-1:0]     quo_q, rem_q;
  logic [sum_w:0]       rem_shift, rem_sub;
  logic [sum_w-1:0]     quo_next, rem_next;
  logic                 q_bit;
  logic                 start_req, start;
  logic                 last_bit;
  logic [div_cnt_w-1:0] bit_cnt;
  div_state_e           state;

  assign start_req = beat_d.new_frame && (n_acc != '0);
  assign start = start_req && (state == idle);  // busy divider drops the frame

  // one restoring step, dividend shifted in msb first through quo_q
  assign rem_shift = {rem_q, quo_q[sum_w-1]};
  assign rem_sub = rem_shift - {1'b0, den_q};
  assign q_bit = ~rem_sub[sum_w];  // no borrow
  assign rem_next = q_bit ? rem_sub[sum_w-1:0] : rem_shift[sum_w-1:0];
  assign quo_next = {quo_q[sum_w-2:0], q_bit};
  assign last_bit = (bit_cnt == div_cnt_w'(sum_w - 1));

  assign saber_valid = (state == done);

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      x_acc <= '0;
      y_acc <= '0;
      n_acc <= '0;
    end else if (beat_d.new_frame) begin
      // boundary beat belongs to the next frame
      x_acc <= saber_mask ? sum_w'(beat_d.hcount) : '0;
      y_acc <= saber_mask ? sum_w'(beat_d.vcount) : '0;
      n_acc <= sum_w'(saber_mask);
    end else if (saber_mask) begin
      x_acc <= x_acc + sum_w'(beat_d.hcount);
      y_acc <= y_acc + sum_w'(beat_d.vcount);
      n_acc <= n_acc + 1'b1;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state   <= idle;
      bit_cnt <= '0;
    end else begin
      case (state)
        idle: begin
          bit_cnt <= '0;
          if (start) state <= divide_x;
        end
        divide_x: begin
          bit_cnt <= bit_cnt + 1'b1;  // wraps to zero for the y pass
          if (last_bit) state <= divide_y;
        end
        divide_y: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) state <= done;
        end
        done:    state <= idle;  // one beat of saber_valid
        default: state <= idle;
      endcase
    end
  end

  // divider datapath
  always_ff @(posedge clk_pixel) begin
    if (start) begin
      den_q   <= n_acc;
      quo_q   <= x_acc;
      num_y_q <= y_acc;
      rem_q   <= '0;
    end else if (state == divide_x && last_bit) begin
      saber_x <= quo_next[h_w-1:0];
      quo_q   <= num_y_q;  // reload for the y quotient
      rem_q   <= '0;
    end else if (state == divide_x || state == divide_y) begin
      quo_q <= quo_next;
      rem_q <= rem_next;
      if (state == divide_y && last_bit) begin
        saber_y <= quo_next[v_w-1:0];
      end
    end
  end

  // a frame pulse while busy must leave the captured frame alone
  a_no_busy_start: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    start_req && (state != idle) |=> $stable(den_q) && $stable(num_y_q));

endmodule

// ==== verilog/color_tracker.sv ====
`timescale 1ns/100ps

module color_tracker import tracker_pkg::*; (
  input  logic        clk_pixel,
  input  logic        sys_rst,
  input  video_beat_t beat,          // one pixel beat per clock
  input  channel_e    channel_sel,   // channel for the shirt mask
  input  logic [3:0]  lower_nib,     // shirt window, upper nibble of the bound
  input  logic [3:0]  upper_nib,
  output rgb_t        pixel_out,     // 5 beats after the input beat
  output logic        pixel_active,
  output location_t   location,
  output logic        box_update,
  output logic        saber_update
);

  video_beat_t    beat_d;
  rgb_t           rgb_d;
  logic           shirt_mask, saber_mask;
  box_t           box;
  logic           box_valid;
  logic [h_w-1:0] saber_x;
  logic [v_w-1:0] saber_y;
  logic           saber_valid;

  mask_stage u_mask (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .beat        (beat),
    .channel_sel (channel_sel),
    .lower_nib   (lower_nib),
    .upper_nib   (upper_nib),
    .beat_d      (beat_d),
    .rgb_d       (rgb_d),
    .shirt_mask  (shirt_mask),
    .saber_mask  (saber_mask)
  );

  bounding_box u_bbox (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .beat_d     (beat_d),
    .shirt_mask (shirt_mask),
    .box        (box),
    .box_valid  (box_valid)
  );

  center_of_mass u_com (
    .clk_pixel   (clk_pixel),
    .sys_rst     (sys_rst),
    .beat_d      (beat_d),
    .saber_mask  (saber_mask),
    .saber_x     (saber_x),
    .saber_y     (saber_y),
    .saber_valid (saber_valid)
  );

  overlay_render u_overlay (
    .clk_pixel    (clk_pixel),
    .sys_rst      (sys_rst),
    .beat_d       (beat_d),
    .rgb_d        (rgb_d),
    .box          (box),
    .box_valid    (box_valid),
    .saber_x      (saber_x),
    .saber_y      (saber_y),
    .saber_valid  (saber_valid),
    .pixel_out    (pixel_out),
    .pixel_active (pixel_active),
    .location     (location),
    .box_update   (box_update),
    .saber_update (saber_update)
  );

endmodule

// ==== verilog/mask_stage.sv ====
`timescale 1ns/100ps

module mask_stage import tracker_pkg::*; (
  input  logic        clk_pixel,
  input  logic        sys_rst,
  input  video_beat_t beat,
  input  channel_e    channel_sel,
  input  logic [3:0]  lower_nib,
  input  logic [3:0]  upper_nib,
  output video_beat_t beat_d,      // beat delayed to line up with the masks
  output rgb_t        rgb_d,
  output logic        shirt_mask,
  output logic        saber_mask
);

  rgb_t             rgb_in;               // 565 expanded to 888
  rgb_t             rgb_pipe [pipe_lat];  // camera pixel delay line
  video_beat_t      beat_pipe [pipe_lat];
  rgb_t             rgb_conv;             // rgb in step with y/cr/cb
  logic [pix_w-1:0] y, cr, cb;
  logic [pix_w-1:0] selected;
  logic [pix_w-1:0] lower_th, upper_th;

  // low bits padded with zeros
  assign rgb_in.r = {beat.rgb565[15:11], 3'b000};
  assign rgb_in.g = {beat.rgb565[10:5], 2'b00};
  assign rgb_in.b = {beat.rgb565[4:0], 3'b000};

  assign lower_th = {lower_nib, 4'b0000};
  assign upper_th = {upper_nib, 4'b0000};

  rgb_to_ycrcb u_ycrcb (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .rgb       (rgb_in),
    .y         (y),
    .cr        (cr),
    .cb        (cb)
  );

  always_ff @(posedge clk_pixel) begin
    rgb_pipe[0] <= rgb_in;
    for (int i = 1; i < pipe_lat; i++) rgb_pipe[i] <= rgb_pipe[i-1];
  end

  // beat delay line with the frame flags
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      for (int i = 0; i < pipe_lat; i++) beat_pipe[i] <= '0;
    end else begin
      beat_pipe[0] <= beat;
      for (int i = 1; i < pipe_lat; i++) beat_pipe[i] <= beat_pipe[i-1];
    end
  end

  assign rgb_conv = rgb_pipe[ycrcb_lat-1];
  assign beat_d = beat_pipe[pipe_lat-1];
  assign rgb_d = rgb_pipe[pipe_lat-1];

  always_comb begin
    case (channel_sel)
      ch_green:             selected = rgb_conv.g;
      ch_red:               selected = rgb_conv.r;
      ch_blue:              selected = rgb_conv.b;
      ch_y:                 selected = y;
      ch_cr:                selected = cr;
      ch_cb:                selected = cb;
      ch_zero_a, ch_zero_b: selected = '0;  // unused codes
      default:              selected = '0;
    endcase
  end

  // both windows inclusive, only inside active picture
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      shirt_mask <= 1'b0;
      saber_mask <= 1'b0;
    end else begin
      shirt_mask <= beat_pipe[pipe_lat-2].active && (selected >= lower_th) &&
                    (selected <= upper_th);
      saber_mask <= beat_pipe[pipe_lat-2].active && (rgb_conv.g >= saber_lo) &&
                    (rgb_conv.g <= saber_hi);
    end
  end

endmodule

// ==== verilog/overlay_render.sv ====
`timescale 1ns/100ps

module overlay_render import tracker_pkg::*; (
  input  logic           clk_pixel,
  input  logic           sys_rst,
  input  video_beat_t    beat_d,
  input  rgb_t           rgb_d,
  input  box_t           box,
  input  logic           box_valid,
  input  logic [h_w-1:0] saber_x,
  input  logic [v_w-1:0] saber_y,
  input  logic           saber_valid,
  output rgb_t           pixel_out,
  output logic           pixel_active,
  output location_t      location,      // player location register
  output logic           box_update,    // high with the new box in location
  output logic           saber_update
);

  logic on_cross;  // pixel on the saber crosshair lines
  logic in_box;    // pixel inside the shirt box, edges included

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      location.box     <= box_none;
      location.saber_x <= '0;
      location.saber_y <= '0;
      box_update       <= 1'b0;
      saber_update     <= 1'b0;
    end else begin
      box_update   <= box_valid;
      saber_update <= saber_valid;
      if (box_valid) begin
        location.box <= box;
      end
      if (saber_valid) begin
        location.saber_x <= saber_x;
        location.saber_y <= saber_y;
      end
    end
  end

  always_comb begin
    on_cross = (beat_d.hcount == location.saber_x) || (beat_d.vcount == location.saber_y);
    in_box   = !location.box.empty &&
               (beat_d.hcount >= location.box.x_min) && (beat_d.hcount <= location.box.x_max) &&
               (beat_d.vcount >= location.box.y_min) && (beat_d.vcount <= location.box.y_max);
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      pixel_active <= 1'b0;
    end else begin
      pixel_active <= beat_d.active;
    end
  end

  // crosshair over box over camera, black in blanking
  always_ff @(posedge clk_pixel) begin
    if (!beat_d.active) begin
      pixel_out <= '0;
    end else if (on_cross) begin
      pixel_out <= {3{crosshair_level}};
    end else if (in_box) begin
      pixel_out <= {3{box_level}};
    end else begin
      pixel_out <= rgb_d;
    end
  end

endmodule

// ==== verilog/rgb_to_ycrcb.sv ====
`timescale 1ns/100ps

// BT.601 studio range, coefficients scaled by 256
module rgb_to_ycrcb import tracker_pkg::*; (
  input  logic             clk_pixel,
  input  logic             sys_rst,
  input  rgb_t             rgb,
  output logic [pix_w-1:0] y,
  output logic [pix_w-1:0] cr,
  output logic [pix_w-1:0] cb
);

  logic signed [17:0] r_s, g_s, b_s;  // zero extended channels
  // stage 1, one product per coefficient
  logic signed [17:0] y_r, y_g, y_b;
  logic signed [17:0] cr_r, cr_g, cr_b;
  logic signed [17:0] cb_r, cb_g, cb_b;
  // stage 2, sums with the offset folded in at 256x
  logic signed [17:0] y_sum, cr_sum, cb_sum;

  assign r_s = {10'd0, rgb.r};
  assign g_s = {10'd0, rgb.g};
  assign b_s = {10'd0, rgb.b};

  // drop the 256 scale and saturate into 8 bits
  function automatic logic [pix_w-1:0] clamp8(input logic signed [17:0] v);
    logic signed [17:0] s;
    s = v >>> 8;
    if (s < 0) return '0;
    else if (s > 18'sd255) return 8'hFF;
    else return s[pix_w-1:0];
  endfunction

  always_ff @(posedge clk_pixel) begin
    y_r  <= 18'sd66 * r_s;
    y_g  <= 18'sd129 * g_s;
    y_b  <= 18'sd25 * b_s;
    cr_r <= 18'sd112 * r_s;
    cr_g <= 18'sd94 * g_s;   // subtracted below
    cr_b <= 18'sd18 * b_s;   // subtracted below
    cb_r <= 18'sd38 * r_s;   // subtracted below
    cb_g <= 18'sd74 * g_s;   // subtracted below
    cb_b <= 18'sd112 * b_s;
  end

  always_ff @(posedge clk_pixel) begin
    y_sum  <= y_r + y_g + y_b + 18'sd4096;         // +16
    cr_sum <= cr_r - cr_g - cr_b + 18'sd32768;     // +128
    cb_sum <= cb_b - cb_r - cb_g + 18'sd32768;     // +128
  end

  // stage 3
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      y  <= '0;
      cr <= '0;
      cb <= '0;
    end else begin
      y  <= clamp8(y_sum);
      cr <= clamp8(cr_sum);
      cb <= clamp8(cb_sum);
    end
  end

endmodule

// ==== verilog/tracker_pkg.sv ====
package tracker_pkg;

  // coordinate widths, same as the video timing counters
  localparam int h_w = 11;
  localparam int v_w = 10;
  localparam int pix_w = 8;  // one colour channel

  // latency of the mask path from input beat to mask bit
  localparam int pipe_lat = 4;
  localparam int ycrcb_lat = 3;  // colour converter depth

  // fixed green band of the saber, inclusive on both ends
  localparam logic [pix_w-1:0] saber_lo = 8'h30;
  localparam logic [pix_w-1:0] saber_hi = 8'h50;

  localparam logic [pix_w-1:0] crosshair_level = 8'hF2;  // light grey
  localparam logic [pix_w-1:0] box_level = 8'hFF;  // white

  // centre of mass sums and divider width
  localparam int sum_w = 32;
  localparam int div_cnt_w = $clog2(sum_w);  // bit counter of the divider

  // channel select codes, 3 and 7 give a zero channel
  typedef enum logic [2:0] {
    ch_green  = 3'd0,
    ch_red    = 3'd1,
    ch_blue   = 3'd2,
    ch_zero_a = 3'd3,
    ch_y      = 3'd4,
    ch_cr     = 3'd5,
    ch_cb     = 3'd6,
    ch_zero_b = 3'd7
  } channel_e;

  // divider sequence, x first and then y
  typedef enum logic [1:0] {
    idle,
    divide_x,
    divide_y,
    done
  } div_state_e;

  typedef struct packed {
    logic [h_w-1:0] hcount;
    logic [v_w-1:0] vcount;
    logic [15:0]    rgb565;     // camera pixel, 5-6-5
    logic           active;     // inside the active picture
    logic           new_frame;  // single beat at the frame boundary
  } video_beat_t;

  typedef struct packed {
    logic [pix_w-1:0] r;
    logic [pix_w-1:0] g;
    logic [pix_w-1:0] b;
  } rgb_t;

  typedef struct packed {
    logic [h_w-1:0] x_min;
    logic [v_w-1:0] y_min;
    logic [h_w-1:0] x_max;
    logic [v_w-1:0] y_max;
    logic           empty;  // no shirt pixel in the frame
  } box_t;

  typedef struct packed {
    box_t           box;
    logic [h_w-1:0] saber_x;
    logic [v_w-1:0] saber_y;
  } location_t;

  // box value with nothing in it
  localparam box_t box_none = '{x_min: '0, y_min: '0, x_max: '0, y_max: '0, empty: 1'b1};

endpackage
